// ==== filelist.f ====
+incdir+include
verilog/rv64_pkg.sv
verilog/rv64_decoder.sv
verilog/rv64_regfile.sv
verilog/rv64_alu.sv
verilog/rv64_load_store.sv
verilog/rv64_core.sv
bench/rv64_core_tb.sv

// ==== run.sh ====
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -f filelist.f --top-module rv64_core_tb \
    -o rv64_core_sim && ./obj_dir/rv64_core_sim || exit 1

// ==== bench/rv64_core_tb.sv ====
`timescale 1ns/10ps
`include "rv64_macros.svh"

module rv64_core_tb
    import rv64_pkg::*;
;

    localparam int NUM_INSTR   = 3000;
    localparam int CYCLE_LIMIT = 4 * NUM_INSTR + 20;

    logic             clock;
    logic             reset_n;
    logic             enable;
    logic [`ILEN-1:0] ir;
    logic [`XLEN-1:0] pc;
    logic [`XLEN-1:0] mem_addr;
    logic [`XLEN-1:0] mem_data_out;
    mem_size_e        mem_size;
    logic             mem_we;
    logic [`XLEN-1:0] mem_data_in;

    logic [7:0]       mem [logic [`XLEN-1:0]];      // Sparse byte memory
    int               mem_version;                  // Bumped on every store
    int               cycles;
    logic [31:0]      rng;
    logic [`XLEN-1:0] m_regs [`REG_COUNT];          // Reference register file
    logic [`XLEN-1:0] m_pc;
    logic [4:0]       last_rd;                      // Recent destination, reused as source
    logic [6:0]       opc;                          // Fields of the instruction in flight
    logic [4:0]       rd;
    logic [4:0]       rs1;
    logic [4:0]       rs2;
    logic [2:0]       f3;
    logic             alt;                          // funct7[5], SUB and SRA
    logic [`XLEN-1:0] imm;

    rv64_core i_rv64_core (
        .clock(clock), .reset_n(reset_n), .enable(enable), .ir(ir), .pc(pc),
        .mem_addr(mem_addr), .mem_data_out(mem_data_out), .mem_size(mem_size),
        .mem_we(mem_we), .mem_data_in(mem_data_in)
    );

    initial begin
        clock = 1'b0;
        forever #10 clock = ~clock;                 // 20 ns period
    end

    function automatic logic [31:0] next_rand();
        rng = rng ^ (rng << 13);
        rng = rng ^ (rng >> 17);
        rng = rng ^ (rng << 5);
        return rng;
    endfunction

    // Unwritten bytes fold every address byte together
    function automatic logic [7:0] mem_byte(input logic [`XLEN-1:0] a);
        logic [7:0] fold;
        fold = 8'h3c;
        for (int i = 0; i < 8; i++) begin
            fold = fold ^ a[8*i +: 8];
        end
        return mem.exists(a) ? mem[a] : fold;
    endfunction

    function automatic logic [`XLEN-1:0] read_dword(input logic [`XLEN-1:0] a, input int version);
        logic [`XLEN-1:0] d;
        for (int i = 0; i < 8; i++) begin
            d[8*i +: 8] = mem_byte(a + 64'(i));
        end
        return d;
    endfunction

    // Version argument retriggers the read after a store
    assign mem_data_in = read_dword(mem_addr, mem_version);

    always @(posedge clock) begin
        if (mem_we) begin
            for (int i = 0; i < (1 << mem_size); i++) begin
                mem[mem_addr + 64'(i)] = mem_data_out[8*i +: 8];
            end
            mem_version = mem_version + 1;
        end
    end

    always @(posedge clock) begin
        cycles = cycles + 1;
        if (cycles >= CYCLE_LIMIT) begin
            $display("** FAIL **");
            $fatal(1, "Timeout, the run did not finish within %0d cycles", CYCLE_LIMIT);
        end
    end

    task automatic compare_value(input string name, input logic [`XLEN-1:0] expected,
                                 input logic [`XLEN-1:0] actual);
        if (expected !== actual) begin
            $display("ERR %s expected %h actual %h", name, expected, actual);
            $display("** FAIL **");
            $fatal(1, "Value mismatch on %s", name);
        end
    endtask

    function automatic logic [4:0] pick_reg();
        logic [31:0] r;
        r = next_rand();
        return r[31] ? last_rd : r[4:0];            // Half the time reuse a fresh result
    endfunction

    function automatic logic [`XLEN-1:0] alu_model(input logic [2:0] f, input logic sub_sra,
                                                   input logic [`XLEN-1:0] a,
                                                   input logic [`XLEN-1:0] b);
        case (f)
            3'b000: return sub_sra ? a - b : a + b;
            3'b001: return a << b[5:0];
            3'b010: return {63'b0, ($signed(a) < $signed(b))};
            3'b011: return {63'b0, (a < b)};
            3'b100: return a ^ b;
            3'b101: begin
                if (sub_sra) begin
                    return $signed(a) >>> b[5:0];
                end
                return a >> b[5:0];
            end
            3'b110: return a | b;
            default: return a & b;
        endcase
    endfunction

    function automatic logic taken_model(input logic [2:0] f, input logic [`XLEN-1:0] a,
                                         input logic [`XLEN-1:0] b);
        case (f)
            3'b000: return a == b;
            3'b001: return a != b;
            3'b100: return $signed(a) < $signed(b);
            3'b101: return $signed(a) >= $signed(b);
            3'b110: return a < b;
            default: return a >= b;
        endcase
    endfunction

    function automatic logic [`XLEN-1:0] load_model(input logic [`XLEN-1:0] a,
                                                    input logic [2:0] f);
        logic [`XLEN-1:0] d;
        d = read_dword(a, mem_version);
        case (f)
            3'b000: return {{56{d[7]}}, d[7:0]};                // LB
            3'b001: return {{48{d[15]}}, d[15:0]};
            3'b010: return {{32{d[31]}}, d[31:0]};
            3'b100: return {56'b0, d[7:0]};                     // LBU
            3'b101: return {48'b0, d[15:0]};
            3'b110: return {32'b0, d[31:0]};
            default: return d;                                  // LD
        endcase
    endfunction

    function automatic logic [`XLEN-1:0] size_mask(input logic [1:0] s);
        case (s)
            2'b00: return 64'hff;
            2'b01: return 64'hffff;
            2'b10: return 64'hffff_ffff;
            default: return '1;
        endcase
    endfunction

    // Random legal instruction; fields kept for the model
    task automatic gen_instr(output logic [`ILEN-1:0] instr);
        logic [31:0] r;
        logic [1:0]  low2;
        int          sel;
        r   = next_rand();
        sel = int'(r[15:0]) % 20;
        rd  = 5'(next_rand());
        rs1 = pick_reg();
        rs2 = pick_reg();
        f3  = 3'(next_rand());
        alt = 1'b0;
        r   = next_rand();
        imm = {{52{r[31]}}, r[31:20]};                          // I and S immediates
        if (sel < 5) begin
            opc = op_imm;
            if (f3 == 3'b001 || f3 == 3'b101) begin
                alt = (f3 == 3'b101) && r[30];
                imm = {52'b0, 1'b0, alt, 4'b0, r[25:20]};       // 6-bit shamt
            end
            instr = {imm[11:0], rs1, f3, rd, opc};
        end else if (sel < 8) begin
            opc   = op_reg;
            alt   = (f3 == 3'b000 || f3 == 3'b101) && r[30];
            instr = {1'b0, alt, 5'b0, rs2, rs1, f3, rd, opc};
        end else if (sel < 10) begin
            opc   = (sel == 8) ? op_lui : op_auipc;
            imm   = {{32{r[31]}}, r[31:12], 12'b0};
            instr = {r[31:12], rd, opc};
        end else if (sel == 10) begin
            opc   = op_jal;
            imm   = {{43{r[31]}}, r[31:13], 2'b00};             // Word aligned offset
            instr = {imm[20], imm[10:1], imm[11], imm[19:12], rd, opc};
        end else if (sel == 11) begin
            opc   = op_jalr;
            low2  = {1'b0, r[20]} - m_regs[rs1][1:0];           // Sum ends in 00 or 01
            imm   = {{52{r[31]}}, r[31:22], low2};
            instr = {imm[11:0], rs1, 3'b000, rd, opc};
        end else if (sel < 14) begin
            opc   = op_branch;
            f3    = (f3[2:1] == 2'b01) ? (f3 ^ 3'b010) : f3;    // Skip funct3 010, 011
            imm   = {{51{r[31]}}, r[31:21], 2'b00};
            instr = {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], opc};
        end else if (sel < 19) begin
            rs1 = r[0] ? 5'd0 : rs1;                            // Small addresses collide
            if (sel < 16) begin
                opc   = op_load;
                f3    = (f3 == 3'b111) ? 3'b011 : f3;
                instr = {imm[11:0], rs1, f3, rd, opc};
            end else begin
                opc   = op_store;
                f3    = {1'b0, f3[1:0]};
                instr = {imm[11:5], rs2, rs1, f3, imm[4:0], opc};
            end
        end else begin
            case (r[1:0])                                       // FENCE, SYSTEM, the W groups
                2'b00: opc = 7'b0001111;
                2'b01: opc = 7'b1110011;
                2'b10: opc = 7'b0011011;
                default: opc = 7'b0111011;
            endcase
            instr = {r[31:7], opc};
        end
    endtask

    // Runs mid-cycle while the DUT outputs are settled
    task automatic step_model();
        logic [`XLEN-1:0] a;
        logic [`XLEN-1:0] b;
        logic [`XLEN-1:0] next_pc;
        logic [`XLEN-1:0] wb;
        logic             wr;
        logic             is_store;
        a        = m_regs[rs1];
        b        = m_regs[rs2];
        next_pc  = m_pc + 64'd4;
        wb       = '0;
        wr       = 1'b1;
        is_store = enable && (opc == op_store);
        compare_value("pc", m_pc, pc);
        compare_value("mem_we", {63'b0, is_store}, {63'b0, mem_we});
        case (opc)
            op_lui:   wb = imm;
            op_auipc: wb = m_pc + imm;
            op_jal: begin
                wb      = m_pc + 64'd4;
                next_pc = m_pc + imm;
            end
            op_jalr: begin
                wb      = m_pc + 64'd4;
                next_pc = (a + imm) & ~64'd1;
            end
            op_branch: begin
                wr = 1'b0;
                if (taken_model(f3, a, b)) begin
                    next_pc = m_pc + imm;
                end
            end
            op_load: wb = load_model(a + imm, f3);
            op_imm:  wb = alu_model(f3, alt, a, imm);
            op_reg:  wb = alu_model(f3, alt, a, b);
            default: wr = 1'b0;                                 // Store or no-op
        endcase
        if (is_store) begin
            compare_value("mem_addr", a + imm, mem_addr);
            compare_value("mem_size", {62'b0, f3[1:0]}, {62'b0, mem_size});
            compare_value("mem_data_out", b & size_mask(f3[1:0]), mem_data_out);
        end
        if (enable) begin
            m_pc = next_pc;
            if (wr && rd != 5'd0) begin
                m_regs[rd] = wb;
                last_rd    = rd;
            end
        end
    endtask

    initial begin
        int               done;
        logic [31:0]      en_r;
        logic [`ILEN-1:0] instr;
        rng         = 32'h5e1d4570;
        mem_version = 0;
        cycles      = 0;
        reset_n     <= 1'b0;
        enable      <= 1'b0;
        ir          <= 32'h0000_0013;                           // ADDI x0, x0, 0
        m_pc        = `RESET_PC;
        last_rd     = 5'd0;
        for (int i = 0; i < `REG_COUNT; i++) begin
            m_regs[i] = '0;
        end
        repeat (5) @(posedge clock);
        reset_n <= 1'b1;
        @(negedge clock);
        compare_value("pc", `RESET_PC, pc);
        compare_value("mem_we", 64'd0, {63'b0, mem_we});
        done = 0;
        while (done < NUM_INSTR) begin
            @(posedge clock);
            gen_instr(instr);
            en_r   = next_rand();
            enable <= (en_r[2:0] != 3'b000);                    // Low about one in eight
            ir     <= instr;
            @(negedge clock);
            step_model();
            if (enable) begin
                done++;
            end
        end
        @(posedge clock);
        enable <= 1'b0;
        @(negedge clock);
        compare_value("pc", m_pc, pc);                          // Target of the last one
        $display("** PASS **");
        $finish;
    end

endmodule

// ==== verilog/rv64_core.sv ====
`timescale 1ns/10ps
`include "rv64_macros.svh"

module rv64_core
    import rv64_pkg::*;
(
    input  logic             clock,
    input  logic             reset_n,
    input  logic             enable,                    // Low holds all state
    input  logic [`ILEN-1:0] ir,
    output logic [`XLEN-1:0] pc,
    output logic [`XLEN-1:0] mem_addr,
    output logic [`XLEN-1:0] mem_data_out,
    output mem_size_e        mem_size,
    output logic             mem_we,
    input  logic [`XLEN-1:0] mem_data_in
);

    logic [`REG_ADDR_W-1:0] rs1_addr;
    logic [`REG_ADDR_W-1:0] rs2_addr;
    logic [`REG_ADDR_W-1:0] rd_addr;
    logic [`XLEN-1:0]       imm;
    alu_op_e                alu_op;
    logic                   alu_use_imm;
    branch_e                branch_kind;
    logic                   is_branch;
    logic                   is_jal;
    logic                   is_jalr;
    wb_src_e                wb_src;
    logic                   load;
    logic                   store;
    logic                   load_unsigned;
    logic [`XLEN-1:0]       rs1_data;
    logic [`XLEN-1:0]       rs2_data;
    logic [`XLEN-1:0]       alu_result;
    logic                   branch_taken;
    logic [`XLEN-1:0]       load_data;
    logic [`XLEN-1:0]       wb_data;
    logic                   rd_we;
    logic [`XLEN-1:0]       pc_plus4;
    logic [`XLEN-1:0]       pc_plus_imm;
    logic [`XLEN-1:0]       pc_next;

    rv64_decoder i_decoder (
        .ir(ir), .rs1_addr(rs1_addr), .rs2_addr(rs2_addr), .rd_addr(rd_addr),
        .imm(imm), .alu_op(alu_op), .alu_use_imm(alu_use_imm),
        .branch_kind(branch_kind), .is_branch(is_branch), .is_jal(is_jal),
        .is_jalr(is_jalr), .wb_src(wb_src), .load(load), .store(store),
        .mem_size(mem_size), .load_unsigned(load_unsigned)
    );

    rv64_regfile i_regfile (
        .clock(clock), .reset_n(reset_n),
        .rs1_addr(rs1_addr), .rs2_addr(rs2_addr),
        .rs1_data(rs1_data), .rs2_data(rs2_data),
        .rd_addr(rd_addr), .rd_data(wb_data), .rd_we(rd_we)
    );

    rv64_alu i_alu (
        .alu_op(alu_op), .alu_use_imm(alu_use_imm),
        .rs1_data(rs1_data), .rs2_data(rs2_data), .imm(imm),
        .branch_kind(branch_kind), .result(alu_result), .branch_taken(branch_taken)
    );

    rv64_load_store i_load_store (
        .load(load), .store(store && enable),           // No store while halted
        .mem_size(mem_size), .load_unsigned(load_unsigned),
        .addr(alu_result), .rs2_data(rs2_data), .mem_data_in(mem_data_in),
        .mem_addr(mem_addr), .mem_data_out(mem_data_out), .mem_we(mem_we),
        .load_data(load_data)
    );

    assign pc_plus4    = pc + `XLEN'd4;
    assign pc_plus_imm = pc + imm;                      // JAL and branch target, AUIPC value

    always_comb begin
        if (is_jalr) begin
            pc_next = {alu_result[`XLEN-1:1], 1'b0};    // Bit 0 cleared
        end else if (is_jal || (is_branch && branch_taken)) begin
            pc_next = pc_plus_imm;
        end else begin
            pc_next = pc_plus4;
        end
    end

    // Write-back mux
    always_comb begin
        case (wb_src)
            wb_alu:    wb_data = alu_result;
            wb_imm:    wb_data = imm;
            wb_pc_imm: wb_data = pc_plus_imm;
            wb_pc4:    wb_data = pc_plus4;
            wb_load:   wb_data = load_data;
            default:   wb_data = '0;
        endcase
    end

    assign rd_we = enable && (wb_src != wb_none);

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            pc <= `RESET_PC;
        end else if (enable) begin
            pc <= pc_next;                              // One instruction per cycle
        end
    end

    pc_aligned: assert property (@(posedge clock) disable iff (!reset_n)
        pc[1:0] == 2'b00);

    no_store_halted: assert property (@(posedge clock) disable iff (!reset_n)
        !enable |-> !mem_we);

endmodule

// ==== verilog/rv64_load_store.sv ====
`timescale 1ns/10ps
`include "rv64_macros.svh"

module rv64_load_store
    import rv64_pkg::*;
(
    input  logic             load,
    input  logic             store,
    input  mem_size_e        mem_size,
    input  logic             load_unsigned,
    input  logic [`XLEN-1:0] addr,
    input  logic [`XLEN-1:0] rs2_data,
    input  logic [`XLEN-1:0] mem_data_in,
    output logic [`XLEN-1:0] mem_addr,
    output logic [`XLEN-1:0] mem_data_out,
    output logic             mem_we,
    output logic [`XLEN-1:0] load_data
);

    logic [`XLEN-1:0] load_ext;
    logic             sign_fill;                            // Fill bit for upper bytes

    assign mem_addr = addr;
    assign mem_we   = store;                                // Already gated by enable

    // Store data zero extended above the access size
    always_comb begin
        case (mem_size)
            size_byte: mem_data_out = {{(`XLEN-8){1'b0}}, rs2_data[7:0]};
            size_half: mem_data_out = {{(`XLEN-16){1'b0}}, rs2_data[15:0]};
            size_word: mem_data_out = {{(`XLEN-32){1'b0}}, rs2_data[31:0]};
            default:   mem_data_out = rs2_data;
        endcase
    end

    always_comb begin
        case (mem_size)
            size_byte: sign_fill = mem_data_in[7];
            size_half: sign_fill = mem_data_in[15];
            default:   sign_fill = mem_data_in[31];
        endcase
        sign_fill = sign_fill & ~load_unsigned;
        case (mem_size)
            size_byte: load_ext = {{(`XLEN-8){sign_fill}}, mem_data_in[7:0]};
            size_half: load_ext = {{(`XLEN-16){sign_fill}}, mem_data_in[15:0]};
            size_word: load_ext = {{(`XLEN-32){sign_fill}}, mem_data_in[31:0]};
            default:   load_ext = mem_data_in;              // LD
        endcase
    end

    assign load_data = load ? load_ext : '0;

endmodule

// ==== verilog/rv64_alu.sv ====
`timescale 1ns/10ps
`include "rv64_macros.svh"

module rv64_alu
    import rv64_pkg::*;
(
    input  alu_op_e          alu_op,
    input  logic             alu_use_imm,
    input  logic [`XLEN-1:0] rs1_data,
    input  logic [`XLEN-1:0] rs2_data,
    input  logic [`XLEN-1:0] imm,
    input  branch_e          branch_kind,
    output logic [`XLEN-1:0] result,
    output logic             branch_taken
);

    logic [`XLEN-1:0] op_b;
    logic [5:0]       shamt;
    logic             eq;
    logic             lt_s;
    logic             lt_u;

    assign op_b  = alu_use_imm ? imm : rs2_data;
    assign shamt = op_b[5:0];                               // 64-bit shifts need 6 bits

    always_comb begin
        case (alu_op)
            alu_sub:  result = rs1_data - op_b;
            alu_slt:  result = {{(`XLEN-1){1'b0}}, $signed(rs1_data) < $signed(op_b)};
            alu_sltu: result = {{(`XLEN-1){1'b0}}, rs1_data < op_b};
            alu_xor:  result = rs1_data ^ op_b;
            alu_or:   result = rs1_data | op_b;
            alu_and:  result = rs1_data & op_b;
            alu_sll:  result = rs1_data << shamt;
            alu_srl:  result = rs1_data >> shamt;
            alu_sra:  result = $signed(rs1_data) >>> shamt;
            default:  result = rs1_data + op_b;             // Also load/store/JALR sums
        endcase
    end

    // Branch compares always use rs2 and never the immediate
    assign eq   = (rs1_data == rs2_data);
    assign lt_s = ($signed(rs1_data) < $signed(rs2_data));
    assign lt_u = (rs1_data < rs2_data);

    always_comb begin
        case (branch_kind)
            br_eq:   branch_taken = eq;
            br_ne:   branch_taken = !eq;
            br_lt:   branch_taken = lt_s;
            br_ge:   branch_taken = !lt_s;
            br_ltu:  branch_taken = lt_u;
            br_geu:  branch_taken = !lt_u;
            default: branch_taken = 1'b0;                   // funct3 010 and 011 unused
        endcase
    end

endmodule

// ==== verilog/rv64_regfile.sv ====
`timescale 1ns/10ps
`include "rv64_macros.svh"

module rv64_regfile (
    input  logic                   clock,
    input  logic                   reset_n,
    input  logic [`REG_ADDR_W-1:0] rs1_addr,
    input  logic [`REG_ADDR_W-1:0] rs2_addr,
    output logic [`XLEN-1:0]       rs1_data,
    output logic [`XLEN-1:0]       rs2_data,
    input  logic [`REG_ADDR_W-1:0] rd_addr,
    input  logic [`XLEN-1:0]       rd_data,
    input  logic                   rd_we
);

    logic [`XLEN-1:0] regs [`REG_COUNT];

    // Asynchronous reads
    assign rs1_data = regs[rs1_addr];
    assign rs2_data = regs[rs2_addr];

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            for (int i = 0; i < `REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (rd_we && rd_addr != '0) begin          // Writes to x0 dropped
            regs[rd_addr] <= rd_data;
        end
    end

    // x0 storage never picks up a write
    x0_reads_zero: assert property (@(posedge clock) disable iff (!reset_n)
        (rs1_addr != '0 || rs1_data == '0) && (rs2_addr != '0 || rs2_data == '0));

endmodule

// ==== verilog/rv64_decoder.sv ====
`timescale 1ns/10ps
`include "rv64_macros.svh"

module rv64_decoder
    import rv64_pkg::*;
(
    input  logic [`ILEN-1:0]       ir,
    output logic [`REG_ADDR_W-1:0] rs1_addr,
    output logic [`REG_ADDR_W-1:0] rs2_addr,
    output logic [`REG_ADDR_W-1:0] rd_addr,
    output logic [`XLEN-1:0]       imm,
    output alu_op_e                alu_op,
    output logic                   alu_use_imm,
    output branch_e                branch_kind,
    output logic                   is_branch,
    output logic                   is_jal,
    output logic                   is_jalr,
    output wb_src_e                wb_src,
    output logic                   load,
    output logic                   store,
    output mem_size_e              mem_size,
    output logic                   load_unsigned
);

    opcode_e          opcode;
    logic [2:0]       funct3;
    logic             alt_bit;                      // funct7[5] picks sub and sra
    logic [`XLEN-1:0] imm_i;
    logic [`XLEN-1:0] imm_s;
    logic [`XLEN-1:0] imm_b;
    logic [`XLEN-1:0] imm_u;
    logic [`XLEN-1:0] imm_j;

    assign opcode   = opcode_e'(ir[6:0]);
    assign rd_addr  = ir[11:7];
    assign funct3   = ir[14:12];
    assign rs1_addr = ir[19:15];
    assign rs2_addr = ir[24:20];
    assign alt_bit  = ir[30];

    // Immediate formats, all sign extended from ir[31]
    assign imm_i = {{(`XLEN-12){ir[31]}}, ir[31:20]};           // Low 6 bits double as shamt
    assign imm_s = {{(`XLEN-12){ir[31]}}, ir[31:25], ir[11:7]};
    assign imm_b = {{(`XLEN-13){ir[31]}}, ir[31], ir[7], ir[30:25], ir[11:8], 1'b0};
    assign imm_u = {{(`XLEN-32){ir[31]}}, ir[31:12], 12'b0};
    assign imm_j = {{(`XLEN-21){ir[31]}}, ir[31], ir[19:12], ir[20], ir[30:21], 1'b0};

    assign branch_kind   = branch_e'(funct3);
    assign mem_size      = mem_size_e'(funct3[1:0]);
    assign load_unsigned = funct3[2];                           // LBU LHU LWU

    always_comb begin
        imm         = imm_i;
        alu_op      = alu_add;                                  // Address and JALR sum
        alu_use_imm = 1'b0;
        is_branch   = 1'b0;
        is_jal      = 1'b0;
        is_jalr     = 1'b0;
        wb_src      = wb_none;                                  // Unknown opcode is a no-op
        load        = 1'b0;
        store       = 1'b0;
        case (opcode)
            op_lui: begin
                imm    = imm_u;
                wb_src = wb_imm;
            end
            op_auipc: begin
                imm    = imm_u;
                wb_src = wb_pc_imm;
            end
            op_jal: begin
                imm    = imm_j;
                is_jal = 1'b1;
                wb_src = wb_pc4;
            end
            op_jalr: begin
                alu_use_imm = 1'b1;
                is_jalr     = 1'b1;
                wb_src      = wb_pc4;
            end
            op_branch: begin
                imm       = imm_b;
                is_branch = 1'b1;                               // Compare done on rs1 and rs2
            end
            op_load: begin
                alu_use_imm = 1'b1;
                load        = 1'b1;
                wb_src      = wb_load;
            end
            op_store: begin
                imm         = imm_s;
                alu_use_imm = 1'b1;
                store       = 1'b1;
            end
            op_imm, op_reg: begin
                alu_use_imm = (opcode == op_imm);
                wb_src      = wb_alu;
                case (funct3)
                    3'b000:  alu_op = (alt_bit && opcode == op_reg) ? alu_sub : alu_add;
                    3'b001:  alu_op = alu_sll;
                    3'b010:  alu_op = alu_slt;
                    3'b011:  alu_op = alu_sltu;
                    3'b100:  alu_op = alu_xor;
                    3'b101:  alu_op = alt_bit ? alu_sra : alu_srl;  // SRAI keeps bit 30 too
                    3'b110:  alu_op = alu_or;
                    default: alu_op = alu_and;
                endcase
            end
            default: begin
            end
        endcase
    end

endmodule

// ==== verilog/rv64_pkg.sv ====
package rv64_pkg;

    // Major opcodes kept by the core
    typedef enum logic [6:0] {
        op_lui    = 7'b0110111,
        op_auipc  = 7'b0010111,
        op_jal    = 7'b1101111,
        op_jalr   = 7'b1100111,
        op_branch = 7'b1100011,
        op_load   = 7'b0000011,
        op_store  = 7'b0100011,
        op_imm    = 7'b0010011,
        op_reg    = 7'b0110011
    } opcode_e;

    typedef enum logic [3:0] {
        alu_add,
        alu_sub,
        alu_slt,
        alu_sltu,
        alu_xor,
        alu_or,
        alu_and,
        alu_sll,
        alu_srl,
        alu_sra
    } alu_op_e;

    // Encoded as the branch funct3
    typedef enum logic [2:0] {
        br_eq  = 3'b000,
        br_ne  = 3'b001,
        br_lt  = 3'b100,
        br_ge  = 3'b101,
        br_ltu = 3'b110,
        br_geu = 3'b111
    } branch_e;

    typedef enum logic [2:0] {
        wb_none,                    // No register write
        wb_alu,
        wb_imm,                     // LUI
        wb_pc_imm,                  // AUIPC
        wb_pc4,                     // Link for JAL and JALR
        wb_load
    } wb_src_e;

    // Same as funct3[1:0] of loads and stores
    typedef enum logic [1:0] {
        size_byte   = 2'b00,
        size_half   = 2'b01,
        size_word   = 2'b10,
        size_double = 2'b11
    } mem_size_e;

endpackage

// ==== include/rv64_macros.svh ====
`ifndef RV64_MACROS_SVH
`define RV64_MACROS_SVH

// Machine widths
`define XLEN        64          // Data and address width
`define ILEN        32          // Instruction width

// Register file geometry
`define REG_COUNT   32          // x0 to x31
`define REG_ADDR_W  5           // Register index width

// Start address after reset
`define RESET_PC    64'h0

`endif
